// ==== design/mem_stage_settings.svh ====
// Memory stage width settings
`ifndef MEM_STAGE_SETTINGS_SVH
`define MEM_STAGE_SETTINGS_SVH

// Data and address width.
`define MEM_XLEN 32

// Byte lanes per data word.
`define MEM_LANES 4

// Trap cause width.
`define MEM_CAUSE_W 4

`endif

// ==== design/mem_stage_pkg.sv ====
// Memory stage types
`include "mem_stage_settings.svh"

package mem_stage_pkg;

    // Major opcodes, instruction bits 6 to 2.
    typedef enum logic [4:0] {
        OP_LOAD  = 5'b00000,
        OP_STORE = 5'b01000,
        OP_AMO   = 5'b01011,
        OP_OTHER = 5'b11111
    } opcode_t;

    // Access size, funct3 bits 13 and 12.
    typedef enum logic [1:0] {
        SIZE_BYTE    = 2'b00,
        SIZE_HALF    = 2'b01,
        SIZE_WORD    = 2'b10,
        SIZE_ILLEGAL = 2'b11
    } asize_t;

    // Read-modify-write operation, instruction bits 31 to 29.
    typedef enum logic [2:0] {
        AMO_ADD  = 3'b000,
        AMO_XOR  = 3'b001,
        AMO_OR   = 3'b010,
        AMO_AND  = 3'b011,
        AMO_MIN  = 3'b100,
        AMO_MAX  = 3'b101,
        AMO_MINU = 3'b110,
        AMO_MAXU = 3'b111
    } amo_op_t;

    // Trap causes raised by this stage.
    typedef enum logic [`MEM_CAUSE_W-1:0] {
        CAUSE_NONE    = `MEM_CAUSE_W'(0),
        CAUSE_ILLEGAL = `MEM_CAUSE_W'(2),
        CAUSE_LALIGN  = `MEM_CAUSE_W'(4),
        CAUSE_SALIGN  = `MEM_CAUSE_W'(6)
    } cause_t;

endpackage

// ==== design/mem_req_if.sv ====
// Memory request interface
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

interface mem_req_if;
    // Request, held in the decode register.
    logic                   valid;
    logic                   is_mem;
    logic                   re;
    logic                   we;
    logic                   rmw_en;
    logic [2:0]             rmw_op;
    logic                   sign;
    mem_stage_pkg::asize_t  asize;
    logic                   illegal;
    logic [`MEM_XLEN-1:0]   addr;
    logic [`MEM_XLEN-1:0]   wdata;
    logic [`MEM_XLEN-1:0]   rs1_val;

    // Response from the bus controller.
    logic                   ealign;
    logic                   ready;
    logic [`MEM_XLEN-1:0]   rdata;

    modport decode (
        output valid, is_mem, re, we, rmw_en, rmw_op, sign, asize, illegal,
        output addr, wdata, rs1_val,
        input  ready
    );

    modport access (
        input  valid, is_mem, re, we, rmw_en, rmw_op, sign, asize, illegal,
        input  addr, wdata, rs1_val,
        output ealign, ready, rdata
    );

    modport result (
        input  valid, is_mem, re, we, rmw_en, rmw_op, sign, asize, illegal,
        input  addr, wdata, rs1_val, ealign, ready, rdata
    );
endinterface

// ==== design/amo_alu.sv ====
// Atomic operation ALU
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module amo_alu (
    input  mem_stage_pkg::amo_op_t  op,
    input  logic [`MEM_XLEN-1:0]    rdata,
    input  logic [`MEM_XLEN-1:0]    operand,
    output logic [`MEM_XLEN-1:0]    result
);
    localparam logic [`MEM_XLEN-1:0] MSB = {1'b1, {(`MEM_XLEN-1){1'b0}}};

    logic                   sub;
    logic                   flip;
    logic [`MEM_XLEN-1:0]   lhs;
    logic [`MEM_XLEN-1:0]   rhs;
    logic [`MEM_XLEN:0]     sum;
    logic                   ge;

    // Min and max subtract; signed ones flip the sign bits first.
    assign sub  = op inside {mem_stage_pkg::AMO_MIN, mem_stage_pkg::AMO_MAX,
                             mem_stage_pkg::AMO_MINU, mem_stage_pkg::AMO_MAXU};
    assign flip = op inside {mem_stage_pkg::AMO_MIN, mem_stage_pkg::AMO_MAX};

    assign lhs = flip ? rdata ^ MSB : rdata;
    assign rhs = (flip ? operand ^ MSB : operand) ^ {`MEM_XLEN{sub}};
    assign sum = {1'b0, lhs} + {1'b0, rhs} + (`MEM_XLEN+1)'(sub);

    // Carry out means the old word is not below the operand.
    assign ge = sum[`MEM_XLEN];

    always_comb begin
        case (op)
            mem_stage_pkg::AMO_ADD:  result = sum[`MEM_XLEN-1:0];
            mem_stage_pkg::AMO_XOR:  result = rdata ^ operand;
            mem_stage_pkg::AMO_OR:   result = rdata | operand;
            mem_stage_pkg::AMO_AND:  result = rdata & operand;
            mem_stage_pkg::AMO_MIN:  result = ge ? operand : rdata;
            mem_stage_pkg::AMO_MAX:  result = ge ? rdata : operand;
            mem_stage_pkg::AMO_MINU: result = ge ? operand : rdata;
            default:                 result = ge ? rdata : operand;
        endcase
    end
endmodule

// ==== design/access_decode.sv ====
// Memory instruction decoder
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module access_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  logic [31:0]             insn,
    input  logic [`MEM_XLEN-1:0]    addr,
    input  logic [`MEM_XLEN-1:0]    wdata,
    output logic                    stall_req,
    mem_req_if.decode               req
);
    logic [4:0]             opcode;
    mem_stage_pkg::asize_t  d_asize;
    logic                   d_is_mem;
    logic                   d_re;
    logic                   d_we;
    logic                   d_rmw_en;
    logic                   d_illegal;
    logic                   accept;

    logic                   r_valid;
    logic                   r_is_mem;
    logic                   r_re;
    logic                   r_we;
    logic                   r_rmw_en;
    logic                   r_illegal;
    logic                   r_sign;
    logic [2:0]             r_rmw_op;
    mem_stage_pkg::asize_t  r_asize;
    logic [`MEM_XLEN-1:0]   r_addr;
    logic [`MEM_XLEN-1:0]   r_wdata;

    assign opcode  = insn[6:2];
    assign d_asize = mem_stage_pkg::asize_t'(insn[13:12]);

    // Classify the instruction.
    always_comb begin
        d_is_mem  = 1'b0;
        d_re      = 1'b0;
        d_we      = 1'b0;
        d_rmw_en  = 1'b0;
        d_illegal = 1'b0;
        case (opcode)
            mem_stage_pkg::OP_LOAD: begin
                d_illegal = d_asize == mem_stage_pkg::SIZE_ILLEGAL;
                d_is_mem  = !d_illegal;
                d_re      = !d_illegal;
            end
            mem_stage_pkg::OP_STORE: begin
                d_illegal = d_asize == mem_stage_pkg::SIZE_ILLEGAL;
                d_is_mem  = !d_illegal;
                d_we      = !d_illegal;
            end
            mem_stage_pkg::OP_AMO: begin
                if (d_asize != mem_stage_pkg::SIZE_WORD) begin
                    d_illegal = 1'b1;
                end else if (insn[28:27] == 2'b00) begin
                    // Read then write of the computed value.
                    d_is_mem = 1'b1;
                    d_rmw_en = 1'b1;
                end else if (insn[28:27] == 2'b01 && insn[31:29] == 3'b000) begin
                    // Swap reads and writes in one access.
                    d_is_mem = 1'b1;
                    d_re     = 1'b1;
                    d_we     = 1'b1;
                end else begin
                    d_illegal = 1'b1;
                end
            end
            default: begin
                d_is_mem = 1'b0;
            end
        endcase
    end

    // Busy until the held request completes.
    assign stall_req = r_valid && !req.ready;
    assign accept    = in_valid && !stall_req;

    always_ff @(posedge clk) begin
        if (rst) begin
            r_valid   <= 1'b0;
            r_is_mem  <= 1'b0;
            r_re      <= 1'b0;
            r_we      <= 1'b0;
            r_rmw_en  <= 1'b0;
            r_illegal <= 1'b0;
        end else if (!stall_req) begin
            r_valid   <= in_valid;
            r_is_mem  <= d_is_mem;
            r_re      <= d_re;
            r_we      <= d_we;
            r_rmw_en  <= d_rmw_en;
            r_illegal <= d_illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            r_sign   <= !insn[14];
            r_rmw_op <= insn[31:29];
            r_asize  <= d_asize;
            r_addr   <= addr;
            r_wdata  <= wdata;
        end
    end

    assign req.valid   = r_valid;
    assign req.is_mem  = r_is_mem;
    assign req.re      = r_re;
    assign req.we      = r_we;
    assign req.rmw_en  = r_rmw_en;
    assign req.rmw_op  = r_rmw_op;
    assign req.sign    = r_sign;
    assign req.asize   = r_asize;
    assign req.illegal = r_illegal;
    assign req.addr    = r_addr;
    assign req.wdata   = r_wdata;
    // The address is the rs1 value.
    assign req.rs1_val = r_addr;
endmodule

// ==== design/mem_bus_ctrl.sv ====
// Data bus controller
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module mem_bus_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    mem_req_if.access               req,
    output logic                    mem_re,
    output logic [`MEM_LANES-1:0]   mem_we,
    output logic [`MEM_XLEN-3:0]    mem_addr,
    output logic [`MEM_XLEN-1:0]    mem_wdata,
    input  logic [`MEM_XLEN-1:0]    mem_rdata,
    input  logic                    mem_ready
);
    // High during the write access of a read-modify-write atomic.
    logic                   phase;
    logic                   go;
    logic                   acc_re;
    logic                   acc_we;
    logic [`MEM_LANES-1:0]  lane_mask;
    logic [`MEM_XLEN-1:0]   amo_result;
    logic [`MEM_XLEN-1:0]   store_data;
    logic [7:0]             rd_byte;
    logic [15:0]            rd_half;

    // Alignment check.
    always_comb begin
        case (req.asize)
            mem_stage_pkg::SIZE_HALF: req.ealign = req.addr[0];
            mem_stage_pkg::SIZE_WORD: req.ealign = req.addr[1:0] != 2'b00;
            default:                  req.ealign = 1'b0;
        endcase
    end

    // Only legal, aligned memory requests reach the bus.
    assign go     = req.valid && req.is_mem && !req.illegal && !req.ealign;
    assign acc_re = req.rmw_en ? !phase : req.re;
    assign acc_we = req.rmw_en ? phase : req.we;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= 1'b0;
        end else if (go && req.rmw_en && mem_ready) begin
            phase <= !phase;
        end
    end

    // The write value is formed from the old word that memory returns with ready.
    amo_alu amo_alu_inst (
        .op      (mem_stage_pkg::amo_op_t'(req.rmw_op)),
        .rdata   (mem_rdata),
        .operand (req.wdata),
        .result  (amo_result)
    );

    assign store_data = req.rmw_en ? amo_result : req.wdata;

    // Lane enables, data replicated across lanes.
    always_comb begin
        case (req.asize)
            mem_stage_pkg::SIZE_BYTE: begin
                lane_mask = `MEM_LANES'(1) << req.addr[1:0];
                mem_wdata = {`MEM_LANES{store_data[7:0]}};
            end
            mem_stage_pkg::SIZE_HALF: begin
                lane_mask = `MEM_LANES'(3) << {req.addr[1], 1'b0};
                mem_wdata = {(`MEM_LANES/2){store_data[15:0]}};
            end
            default: begin
                lane_mask = '1;
                mem_wdata = store_data;
            end
        endcase
    end

    assign mem_re   = go && acc_re;
    assign mem_we   = (go && acc_we) ? lane_mask : '0;
    assign mem_addr = req.addr[`MEM_XLEN-1:2];

    // Read byte and halfword selection.
    assign rd_byte = mem_rdata[8*req.addr[1:0] +: 8];
    assign rd_half = mem_rdata[16*req.addr[1] +: 16];

    always_comb begin
        case (req.asize)
            mem_stage_pkg::SIZE_BYTE:
                req.rdata = {{(`MEM_XLEN-8){req.sign && rd_byte[7]}}, rd_byte};
            mem_stage_pkg::SIZE_HALF:
                req.rdata = {{(`MEM_XLEN-16){req.sign && rd_half[15]}}, rd_half};
            default:
                req.rdata = mem_rdata;
        endcase
    end

    // The first ready of an atomic only moves to the write access.
    assign req.ready = req.valid && (!go || (mem_ready && (!req.rmw_en || phase)));
endmodule

// ==== design/writeback_trap.sv ====
// Result and trap register
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module writeback_trap (
    input  logic                    clk,
    input  logic                    rst,
    mem_req_if.result               resp,
    output logic                    out_valid,
    output logic [`MEM_XLEN-1:0]    rd_val,
    output logic                    trap,
    output mem_stage_pkg::cause_t   cause
);
    logic                   done;
    logic                   bus_read;
    logic                   next_trap;
    mem_stage_pkg::cause_t  next_cause;

    assign done = resp.valid && resp.ready;

    // Loads and atomics that actually read memory.
    assign bus_read = resp.is_mem && !resp.ealign && (resp.re || resp.rmw_en);

    // Illegal wins over misaligned.
    always_comb begin
        next_trap  = 1'b0;
        next_cause = mem_stage_pkg::CAUSE_NONE;
        if (resp.illegal) begin
            next_trap  = 1'b1;
            next_cause = mem_stage_pkg::CAUSE_ILLEGAL;
        end else if (resp.is_mem && resp.ealign) begin
            next_trap  = 1'b1;
            next_cause = (resp.we || resp.rmw_en) ? mem_stage_pkg::CAUSE_SALIGN
                                                  : mem_stage_pkg::CAUSE_LALIGN;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            trap      <= 1'b0;
        end else begin
            out_valid <= done;
            if (done) begin
                trap <= next_trap;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            rd_val <= bus_read ? resp.rdata : resp.rs1_val;
            cause  <= next_cause;
        end
    end
endmodule

// ==== design/mem_stage_top.sv ====
// Memory access stage
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module mem_stage_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  logic [31:0]             insn,
    input  logic [`MEM_XLEN-1:0]    addr,
    input  logic [`MEM_XLEN-1:0]    wdata,
    output logic                    stall_req,
    output logic                    mem_re,
    output logic [`MEM_LANES-1:0]   mem_we,
    output logic [`MEM_XLEN-3:0]    mem_addr,
    output logic [`MEM_XLEN-1:0]    mem_wdata,
    input  logic [`MEM_XLEN-1:0]    mem_rdata,
    input  logic                    mem_ready,
    output logic                    out_valid,
    output logic [`MEM_XLEN-1:0]    rd_val,
    output logic                    trap,
    output mem_stage_pkg::cause_t   cause
);
    mem_req_if req_if ();

    access_decode access_decode_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .insn      (insn),
        .addr      (addr),
        .wdata     (wdata),
        .stall_req (stall_req),
        .req       (req_if.decode)
    );

    mem_bus_ctrl mem_bus_ctrl_inst (
        .clk       (clk),
        .rst       (rst),
        .req       (req_if.access),
        .mem_re    (mem_re),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    writeback_trap writeback_trap_inst (
        .clk       (clk),
        .rst       (rst),
        .resp      (req_if.result),
        .out_valid (out_valid),
        .rd_val    (rd_val),
        .trap      (trap),
        .cause     (cause)
    );
endmodule

// ==== tb/mem_model.sv ====
// Data memory model
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module mem_model #(
    parameter int DEPTH_LOG2 = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    mem_re,
    input  logic [`MEM_LANES-1:0]   mem_we,
    input  logic [`MEM_XLEN-3:0]    mem_addr,
    input  logic [`MEM_XLEN-1:0]    mem_wdata,
    output logic [`MEM_XLEN-1:0]    mem_rdata,
    output logic                    mem_ready
);
    logic [`MEM_XLEN-1:0]   mem [0:(1 << DEPTH_LOG2)-1];
    logic [DEPTH_LOG2-1:0]  index;
    logic                   request;
    // Cycles left before the current access is answered.
    logic [1:0]             wait_cnt;
    integer                 seed = 32'h4a4682b8;

    assign index     = mem_addr[DEPTH_LOG2-1:0];
    assign request   = mem_re || (mem_we != '0);
    assign mem_ready = request && (wait_cnt == 2'd0);

    // Old word, also during the write cycle of a swap.
    assign mem_rdata = mem[index];

    always @(posedge clk) begin : update
        logic [31:0] draw;
        if (rst) begin
            for (int i = 0; i < (1 << DEPTH_LOG2); i++) begin
                mem[i] <= '0;
            end
            draw = $random(seed);
            wait_cnt <= draw[1:0];
        end else if (request) begin
            if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else begin
                for (int lane = 0; lane < `MEM_LANES; lane++) begin
                    if (mem_we[lane]) begin
                        mem[index][8*lane +: 8] <= mem_wdata[8*lane +: 8];
                    end
                end
                // New delay for the next access.
                draw = $random(seed);
                wait_cnt <= draw[1:0];
            end
        end
    end
endmodule

// ==== tb/mem_stage_sva.sv ====
// Memory stage bus assertions
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module mem_stage_sva (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    mem_re,
    input  logic [`MEM_LANES-1:0]   mem_we,
    input  logic [`MEM_XLEN-3:0]    mem_addr,
    input  logic                    mem_ready,
    input  logic                    out_valid
);
    // Request held until memory answers.
    assert property (@(posedge clk) disable iff (rst)
        (mem_re || mem_we != '0) && !mem_ready
        |=> $stable(mem_re) && $stable(mem_we) && $stable(mem_addr))
    else $error("bus request changed while mem_ready was low");

    // One result pulse per instruction.
    assert property (@(posedge clk) disable iff (rst)
        out_valid |=> !out_valid)
    else $error("out_valid high in two consecutive cycles");

    assert property (@(posedge clk)
        rst && $past(rst) |-> !mem_re && mem_we == '0)
    else $error("bus request issued during reset");
endmodule

bind mem_stage_top mem_stage_sva mem_stage_sva_inst (
    .clk       (clk),
    .rst       (rst),
    .mem_re    (mem_re),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_ready (mem_ready),
    .out_valid (out_valid)
);

// ==== tb/tb_mem_stage.sv ====
// Memory stage testbench
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module tb_mem_stage;
    localparam int WAIT_LIMIT = 64;

    logic                       clk;
    logic                       rst;
    logic                       in_valid;
    logic [31:0]                insn;
    logic [`MEM_XLEN-1:0]       addr;
    logic [`MEM_XLEN-1:0]       wdata;
    logic                       stall_req;
    logic                       mem_re;
    logic [`MEM_LANES-1:0]      mem_we;
    logic [`MEM_XLEN-3:0]       mem_addr;
    logic [`MEM_XLEN-1:0]       mem_wdata;
    logic [`MEM_XLEN-1:0]       mem_rdata;
    logic                       mem_ready;
    logic                       out_valid;
    logic [`MEM_XLEN-1:0]       rd_val;
    logic                       trap;
    logic [`MEM_CAUSE_W-1:0]    cause;

    int error_count = 0;
    int timeout_count = 0;
    int line_count = 0;
    int pulse_count = 0;
    bit aborted = 1'b0;

    mem_stage_top mem_stage_top_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .insn      (insn),
        .addr      (addr),
        .wdata     (wdata),
        .stall_req (stall_req),
        .mem_re    (mem_re),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready),
        .out_valid (out_valid),
        .rd_val    (rd_val),
        .trap      (trap),
        .cause     (cause)
    );

    mem_model mem_model_inst (
        .clk       (clk),
        .rst       (rst),
        .mem_re    (mem_re),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Result pulses, compared with the trace length at the end.
    always @(negedge clk) begin
        if (!rst && out_valid) begin
            pulse_count++;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic wait_not_stalled();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (stall_req && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (stall_req) begin
            $display("timeout: stall_req stayed high for %0d cycles", WAIT_LIMIT);
            timeout_count++;
            aborted = 1'b1;
        end
    endtask

    task automatic wait_for_result();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!out_valid && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!out_valid) begin
            $display("timeout: no out_valid within %0d cycles of trace line %0d",
                     WAIT_LIMIT, line_count);
            timeout_count++;
            aborted = 1'b1;
        end
    endtask

    task automatic run_line(input logic [31:0] l_insn, input logic [31:0] l_addr,
                            input logic [31:0] l_wdata, input logic [31:0] exp_rd,
                            input logic [31:0] exp_trap, input logic [31:0] exp_cause);
        line_count++;
        wait_not_stalled();
        if (aborted) begin
            return;
        end
        @(posedge clk);
        in_valid <= 1'b1;
        insn     <= l_insn;
        addr     <= l_addr;
        wdata    <= l_wdata;
        // Accepted on this edge.
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        // Traps and other instructions finish in the cycle after acceptance.
        if (exp_trap != 0 || !(l_insn[6:0] inside {7'h03, 7'h23, 7'h2f})) begin
            check_value("stall_req", 32'd0, 32'(stall_req));
        end else if (l_insn[6:0] == 7'h2f && l_insn[28:27] == 2'b00) begin
            // An aligned read-modify-write atomic still has its write access ahead.
            check_value("stall_req", 32'd1, 32'(stall_req));
        end
        wait_for_result();
        if (!aborted) begin
            check_value("rd_val", exp_rd, rd_val);
            check_value("trap", exp_trap, 32'(trap));
            check_value("cause", exp_cause, 32'(cause));
        end
    endtask

    initial begin
        int fd;
        int fields;
        string text;
        logic [31:0] f_insn;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        logic [31:0] f_rd;
        logic [31:0] f_trap;
        logic [31:0] f_cause;

        rst      = 1'b1;
        in_valid = 1'b0;
        insn     = '0;
        addr     = '0;
        wdata    = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("tb/mem_stage_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file tb/mem_stage_trace.txt");
            error_count++;
        end else begin
            while (!$feof(fd) && !aborted) begin
                text = "";
                if ($fgets(text, fd) != 0) begin
                    fields = $sscanf(text, "%h %h %h %h %h %h",
                                     f_insn, f_addr, f_wdata, f_rd, f_trap, f_cause);
                    // Comment and blank lines carry no fields.
                    if (fields == 6) begin
                        run_line(f_insn, f_addr, f_wdata, f_rd, f_trap, f_cause);
                    end
                end
            end
            $fclose(fd);
        end

        // Let any stray result pulse show up.
        repeat (4) @(negedge clk);
        if (pulse_count != line_count) begin
            $display("%0d trace lines gave %0d out_valid pulses", line_count, pulse_count);
            error_count++;
        end

        $display("summary: %0d lines, %0d errors, %0d timeouts",
                 line_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0 && line_count > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end
endmodule

// ==== compile.f ====
+incdir+design
design/mem_stage_pkg.sv
design/mem_req_if.sv
design/amo_alu.sv
design/access_decode.sv
design/mem_bus_ctrl.sv
design/writeback_trap.sv
design/mem_stage_top.sv
tb/mem_model.sv
tb/mem_stage_sva.sv
tb/tb_mem_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the memory stage testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_stage \
    -f compile.f -o sim_mem_stage > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

{ ./obj_dir/sim_mem_stage > sim.log 2>&1 || true; } \
    && grep -qx "test passed" sim.log \
    && { echo "Simulation PASSED"; exit 0; } \
    || { echo "Simulation FAILED, see sim.log"; exit 1; }

// ==== tb/mem_stage_trace.txt ====
// insn     addr     wdata    rd_val   trap cause
// One instruction per line, all fields in hex.
00002023 00000100 8badf00d 00000100 0 0
00002003 00000100 00000000 8badf00d 0 0
00000003 00000103 00000000 ffffff8b 0 0
00004003 00000103 00000000 0000008b 0 0
00001003 00000102 00000000 ffff8bad 0 0
00005003 00000100 00000000 0000f00d 0 0
00000023 00000101 000000a5 00000101 0 0
00001023 00000106 00001234 00000106 0 0
00002003 00000104 00000000 12340000 0 0
00002003 00000102 00000000 00000102 1 4
00001003 00000101 00000000 00000101 1 4
00002023 00000101 deadbeef 00000101 1 6
0000202f 00000102 00000001 00000102 1 6
00002003 00000100 00000000 8bada50d 0 0
00002023 00000200 80000005 00000200 0 0
0000202f 00000200 00000010 80000005 0 0
2000202f 00000200 0000ffff 80000015 0 0
4000202f 00000200 01000000 8000ffea 0 0
6000202f 00000200 f0f0ffff 8100ffea 0 0
a000202f 00000200 00000007 8000ffea 0 0
8000202f 00000200 fffffff0 00000007 0 0
c000202f 00000200 00000100 fffffff0 0 0
e000202f 00000200 80000000 00000100 0 0
0800202f 00000200 cafe0001 80000000 0 0
00002003 00000200 00000000 cafe0001 0 0
00003003 00000300 00000000 00000300 1 2
00003023 00000300 ffffffff 00000300 1 2
1000202f 00000200 00000000 00000200 1 2
00000033 12345678 00000000 12345678 0 0
00002003 00000300 00000000 00000000 0 0
